/* list.f */
+incdir+hdl
hdl/pkbus_pkg.sv
hdl/mem_map_pkg.sv
hdl/pkbus_master.sv
hdl/pkbus_ram.sv
hdl/pkbus_decoder.sv
hdl/pkbus_subsystem.sv
bench/tb_pkbus_subsystem.sv

/* Bender.yml */
package:
  name: pkbus_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pkbus_pkg.sv
      - hdl/mem_map_pkg.sv
      - hdl/pkbus_master.sv
      - hdl/pkbus_ram.sv
      - hdl/pkbus_decoder.sv
      - hdl/pkbus_subsystem.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/tb_pkbus_subsystem.sv

/* bench/tb_pkbus_subsystem.sv */
// Self-checking testbench for the PKBus segment, directed tests followed by an LFSR command mix
// Compile with list.f and run tb_pkbus_subsystem as the top module
`timescale 1ns/100ps
`include "pkbus_consts.svh"

module tb_pkbus_subsystem import pkbus_pkg::*, mem_map_pkg::*;;

    localparam int HALF_PERIOD    = 50;
    localparam int STIM_DELAY     = 10;  // Inputs change this long after the rising edge
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_CMDS       = 4 + 8 + 9 + 6 + 5 + 200;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 40 + RESET_CYCLES;
    localparam int AW             = $clog2(`RAM_BYTES);

    logic         clk_i;
    logic         reset_i;
    logic         cmd_req_i;
    bus_rw_t      cmd_rw_i;
    bus_size_t    cmd_size_i;
    logic [31:0]  cmd_addr_i;
    logic [127:0] cmd_wdata_i;
    logic         cmd_ack_o;
    logic [127:0] cmd_rdata_o;

    logic [31:0]  lfsr_q;
    logic [7:0]   shadow0 [`RAM_BYTES];  // Expected contents of RAM 0
    logic [7:0]   shadow1 [`RAM_BYTES];
    string        name_q [$];
    logic [127:0] exp_q [$];
    logic [127:0] act_q [$];
    int           checks_queued = 0;
    int           checks_done = 0;
    logic         ack_prev = 1'b0;
    logic         req_prev = 1'b0;

    pkbus_subsystem dut_i (
        .clk_i, .reset_i,
        .cmd_req_i, .cmd_rw_i, .cmd_size_i, .cmd_addr_i, .cmd_wdata_i,
        .cmd_ack_o, .cmd_rdata_o
    );

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};  // One step per bit
        end
        return r;
    endfunction

    function automatic logic [127:0] random_payload();
        logic [127:0] r;
        for (int k = 0; k < 4; k++) begin
            r[32*k +: 32] = random_bits(32);
        end
        return r;
    endfunction

    function automatic logic [31:0] word_offset();
        return random_bits(AW - 2) << 2;  // Aligned offset inside a region
    endfunction

    function automatic int size_bytes(input bus_size_t size);
        case (size)
            SIZE_BYTE:  return 1;
            SIZE_TWORD: return 16;
            default:    return 4;  // Stream code behaves as a word
        endcase
    endfunction

    function automatic slave_sel_t region_of(input logic [31:0] addr);
        if (addr >= `RAM0_BASE && addr < `RAM0_BASE + `RAM_BYTES) begin
            return SEL_RAM0;
        end else if (addr >= `RAM1_BASE && addr < `RAM1_BASE + `RAM_BYTES) begin
            return SEL_RAM1;
        end
        return SEL_NONE;
    endfunction

    function automatic logic [AW-1:0] region_index(input logic [31:0] addr, input int i);
        if (region_of(addr) == SEL_RAM1) begin
            return AW'(addr - `RAM1_BASE + i);  // Wraps inside the region
        end
        return AW'(addr - `RAM0_BASE + i);
    endfunction

    // Reference model of a read, beat 0 in the low word and unused bits zero
    function automatic logic [127:0] expected_read(input logic [31:0] addr, input bus_size_t size);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < size_bytes(size); i++) begin
            case (region_of(addr))
                SEL_RAM0: r[8*i +: 8] = shadow0[region_index(addr, i)];
                SEL_RAM1: r[8*i +: 8] = shadow1[region_index(addr, i)];
                default:  r[8*i +: 8] = 8'h00;
            endcase
        end
        return r;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input bus_size_t size,
                                input logic [127:0] data);
        for (int i = 0; i < size_bytes(size); i++) begin
            if (region_of(addr) == SEL_RAM0) begin
                shadow0[region_index(addr, i)] = data[8*i +: 8];
            end else if (region_of(addr) == SEL_RAM1) begin
                shadow1[region_index(addr, i)] = data[8*i +: 8];
            end
        end
    endtask

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic queue_check(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        checks_queued++;
    endtask

    task automatic next_drive_point();
        @(posedge clk_i);
        #STIM_DELAY;
    endtask

    // Four-phase command, returns the data seen while cmd_ack_o is high
    task automatic run_command(input bus_rw_t rw, input bus_size_t size, input logic [31:0] addr,
                               input logic [127:0] wdata, output logic [127:0] rdata);
        cmd_rw_i    = rw;
        cmd_size_i  = size;
        cmd_addr_i  = addr;
        cmd_wdata_i = wdata;
        cmd_req_i   = 1'b1;
        next_drive_point();
        while (!cmd_ack_o) begin
            next_drive_point();
        end
        rdata     = cmd_rdata_o;
        cmd_req_i = 1'b0;
        next_drive_point();
        while (cmd_ack_o) begin
            next_drive_point();
        end
    endtask

    task automatic write_cmd(input logic [31:0] addr, input bus_size_t size,
                             input logic [127:0] data);
        logic [127:0] ignored_rdata;
        shadow_write(addr, size, data);
        run_command(BUS_WRITE, size, addr, data, ignored_rdata);
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr, input bus_size_t size,
                               input logic [127:0] exp);
        logic [127:0] rdata;
        run_command(BUS_READ, size, addr, random_payload(), rdata);
        queue_check(name, exp, rdata);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, input bus_size_t size);
        read_expect(name, addr, size, expected_read(addr, size));
    endtask

    // Checker works through the results in the order they were taken
    initial begin
        forever begin
            wait (checks_done < checks_queued);
            compare(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
            checks_done++;
        end
    end

    // cmd_ack_o may only rise while a command is pending
    always @(negedge clk_i) begin
        if (!reset_i && cmd_ack_o && !ack_prev && !req_prev) begin
            $display("Handshake failure, cmd_ack_o rose while cmd_req_i was low");
            stop_with_failure();
        end else begin
            ack_prev <= cmd_ack_o;
            req_prev <= cmd_req_i;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout, the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

    initial begin
        logic [31:0]  addr;
        logic [31:0]  bits;
        logic [127:0] data;
        logic [7:0]   b [4];
        bus_size_t    size;
        bus_rw_t      rw;

        lfsr_q      = 32'h962e;
        reset_i     = 1'b1;
        cmd_req_i   = 1'b0;
        cmd_rw_i    = BUS_READ;
        cmd_size_i  = SIZE_WORD;
        cmd_addr_i  = '0;
        cmd_wdata_i = '0;
        for (int i = 0; i < `RAM_BYTES; i++) begin
            shadow0[i] = 8'h00;
            shadow1[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #STIM_DELAY;
        reset_i = 1'b0;

        queue_check("reset_ack", 128'd0, {127'd0, cmd_ack_o});
        read_expect("reset_ram0_low", `RAM0_BASE, SIZE_WORD, 128'd0);
        read_expect("reset_ram0", `RAM0_BASE + word_offset(), SIZE_WORD, 128'd0);
        read_expect("reset_ram1_top", `RAM1_BASE + `RAM_BYTES - 4, SIZE_WORD, 128'd0);
        read_expect("reset_ram1", `RAM1_BASE + word_offset(), SIZE_WORD, 128'd0);

        for (int r = 0; r < 2; r++) begin  // Both wait-state settings
            for (int n = 0; n < 2; n++) begin
                addr = ((r == 0) ? `RAM0_BASE : `RAM1_BASE) + word_offset();
                data = {96'd0, random_bits(32)};
                write_cmd(addr, SIZE_WORD, data);
                read_expect("word_rw", addr, SIZE_WORD, data);
            end
        end

        addr = `RAM0_BASE + word_offset();
        for (int k = 3; k >= 0; k--) begin  // Highest byte first so a full-word store shows up
            data = {96'd0, random_bits(32)};  // Upper bits must not reach the RAM
            b[k] = data[7:0];
            write_cmd(addr + k, SIZE_BYTE, data);
        end
        read_expect("byte_assembly", addr, SIZE_WORD, {96'd0, b[3], b[2], b[1], b[0]});
        for (int k = 0; k < 4; k++) begin
            read_expect("byte_read", addr + k, SIZE_BYTE, {120'd0, b[k]});
        end

        addr = `RAM1_BASE + (word_offset() & 32'hffff_fff0);  // All four beats inside RAM 1
        data = random_payload();
        write_cmd(addr, SIZE_TWORD, data);
        read_expect("tword_read", addr, SIZE_TWORD, data);
        for (int k = 0; k < 4; k++) begin
            read_expect("tword_beat", addr + 4 * k, SIZE_WORD, {96'd0, data[32*k +: 32]});
        end

        addr = 32'h0000_2000 + word_offset();
        write_cmd(addr, SIZE_WORD, random_payload());
        read_expect("unmapped_word", addr, SIZE_WORD, 128'd0);
        read_expect("unmapped_tword", addr, SIZE_TWORD, 128'd0);
        read_check("unmapped_ram0", `RAM0_BASE + (addr & (`RAM_BYTES - 1)), SIZE_WORD);
        read_check("unmapped_ram1", `RAM1_BASE + (addr & (`RAM_BYTES - 1)), SIZE_WORD);

        for (int n = 0; n < 200; n++) begin
            bits = random_bits(2);
            size = bus_size_t'(bits[1:0]);
            bits = random_bits(1);
            rw   = bus_rw_t'(bits[0]);
            addr = random_bits(AW);
            if (size != SIZE_BYTE) begin
                addr = addr & 32'hffff_fffc;
            end
            bits = random_bits(2);
            case (bits[1:0])
                2'd0:    addr = addr + `RAM0_BASE;
                2'd1:    addr = addr + `RAM1_BASE;
                2'd2:    addr = addr + `RAM0_BASE;
                default: addr = addr + (random_bits(1) ? 32'h8000_0000 : 32'h0000_0400);
            endcase
            bits = random_bits(2);
            repeat (bits[1:0]) begin
                next_drive_point();  // Idle gap with cmd_req_i low
            end
            data = random_payload();
            if (rw == BUS_WRITE) begin
                write_cmd(addr, size, data);
            end else begin
                read_check("random_read", addr, size);
            end
        end

        wait (checks_done == checks_queued);
        $display("No errors");
        $finish;
    end

endmodule

/* hdl/pkbus_subsystem.sv */
// PKBus segment top level, one master, the address decoder and two RAM slaves
// Driven through the four-phase command port
`timescale 1ns/100ps
`include "pkbus_consts.svh"

module pkbus_subsystem import pkbus_pkg::*; (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        cmd_req_i,
    input  bus_rw_t                     cmd_rw_i,
    input  bus_size_t                   cmd_size_i,
    input  logic [`BUS_ADDR_SIZE-1:0]   cmd_addr_i,
    input  logic [4*`BUS_DATA_SIZE-1:0] cmd_wdata_i,
    output logic                        cmd_ack_o,
    output logic [4*`BUS_DATA_SIZE-1:0] cmd_rdata_o
);

    logic                      bus_req;
    bus_rw_t                   bus_rw;
    bus_size_t                 bus_size;
    logic [`BUS_ADDR_SIZE-1:0] bus_addr;
    logic [`BUS_DATA_SIZE-1:0] bus_wdata;
    logic                      bus_ack;
    logic                      bus_seqslv;
    logic [`BUS_DATA_SIZE-1:0] bus_rdata;
    logic [`BUS_ADDR_SIZE-1:0] local_addr; // Offset inside the selected region
    logic                      ram0_req, ram0_ack, ram0_seqslv;
    logic                      ram1_req, ram1_ack, ram1_seqslv;
    logic [`BUS_DATA_SIZE-1:0] ram0_rdata;
    logic [`BUS_DATA_SIZE-1:0] ram1_rdata;

    pkbus_master master_i (
        .clk_i, .reset_i,
        .cmd_req_i, .cmd_rw_i, .cmd_size_i, .cmd_addr_i, .cmd_wdata_i,
        .cmd_ack_o, .cmd_rdata_o,
        .bus_req_o (bus_req), .bus_rw_o (bus_rw), .bus_size_o (bus_size),
        .bus_addr_o (bus_addr), .bus_wdata_o (bus_wdata),
        .bus_ack_i (bus_ack), .bus_seqslv_i (bus_seqslv), .bus_rdata_i (bus_rdata)
    );

    pkbus_decoder decoder_i (
        .clk_i, .reset_i,
        .req_i (bus_req), .size_i (bus_size), .addr_i (bus_addr),
        .ack_o (bus_ack), .seqslv_o (bus_seqslv), .rdata_o (bus_rdata),
        .ram0_req_o (ram0_req), .ram1_req_o (ram1_req), .local_addr_o (local_addr),
        .ram0_ack_i (ram0_ack), .ram0_seqslv_i (ram0_seqslv), .ram0_rdata_i (ram0_rdata),
        .ram1_ack_i (ram1_ack), .ram1_seqslv_i (ram1_seqslv), .ram1_rdata_i (ram1_rdata)
    );

    pkbus_ram #(.WAIT_CYCLES(0)) ram0_i (
        .clk_i, .reset_i,
        .req_i (ram0_req), .rw_i (bus_rw), .size_i (bus_size),
        .addr_i (local_addr), .wdata_i (bus_wdata),
        .ack_o (ram0_ack), .seqslv_o (ram0_seqslv), .rdata_o (ram0_rdata)
    );

    pkbus_ram #(.WAIT_CYCLES(2)) ram1_i (
        .clk_i, .reset_i,
        .req_i (ram1_req), .rw_i (bus_rw), .size_i (bus_size),
        .addr_i (local_addr), .wdata_i (bus_wdata),
        .ack_o (ram1_ack), .seqslv_o (ram1_seqslv), .rdata_o (ram1_rdata)
    );

endmodule

/* hdl/pkbus_decoder.sv */
// PKBus address decoder for two RAM regions
// Routes req to one slave, merges the responses and answers unmapped addresses itself
`timescale 1ns/100ps
`include "pkbus_consts.svh"

module pkbus_decoder import pkbus_pkg::*, mem_map_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // Master side
    input  logic                      req_i,
    input  bus_size_t                 size_i,
    input  logic [`BUS_ADDR_SIZE-1:0] addr_i,
    output logic                      ack_o,
    output logic                      seqslv_o,
    output logic [`BUS_DATA_SIZE-1:0] rdata_o,

    // Slave side
    output logic                      ram0_req_o,
    output logic                      ram1_req_o,
    output logic [`BUS_ADDR_SIZE-1:0] local_addr_o,
    input  logic                      ram0_ack_i,
    input  logic                      ram0_seqslv_i,
    input  logic [`BUS_DATA_SIZE-1:0] ram0_rdata_i,
    input  logic                      ram1_ack_i,
    input  logic                      ram1_seqslv_i,
    input  logic [`BUS_DATA_SIZE-1:0] ram1_rdata_i
);

    slave_sel_t sel;
    logic       nm_req;     // Request to an unmapped address
    logic       nm_ack_q;
    logic       nm_seqslv_q;
    logic [1:0] nm_beat_q;
    logic       nm_done_q;

    always_comb begin
        if (addr_i >= `RAM0_BASE && addr_i < `RAM0_BASE + `RAM_BYTES) begin
            sel          = SEL_RAM0;
            local_addr_o = addr_i - `RAM0_BASE;
        end else if (addr_i >= `RAM1_BASE && addr_i < `RAM1_BASE + `RAM_BYTES) begin
            sel          = SEL_RAM1;
            local_addr_o = addr_i - `RAM1_BASE;
        end else begin
            sel          = SEL_NONE;
            local_addr_o = addr_i;
        end
    end

    assign ram0_req_o = req_i && (sel == SEL_RAM0);
    assign ram1_req_o = req_i && (sel == SEL_RAM1);
    assign nm_req     = req_i && (sel == SEL_NONE);

    // Unmapped responder, one cycle per answer and writes go nowhere
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            nm_ack_q    <= 1'b0;
            nm_seqslv_q <= 1'b0;
            nm_beat_q   <= 2'd0;
            nm_done_q   <= 1'b0;
        end else begin
            nm_seqslv_q <= 1'b0;
            if (!nm_req) begin
                nm_ack_q  <= 1'b0;
                nm_beat_q <= 2'd0;
                nm_done_q <= 1'b0;
            end else if (!nm_ack_q && !nm_seqslv_q && !nm_done_q) begin
                if (size_i == SIZE_TWORD) begin
                    nm_seqslv_q <= 1'b1;
                    nm_beat_q   <= nm_beat_q + 2'd1;
                    nm_done_q   <= (nm_beat_q == 2'd3);
                end else begin
                    nm_ack_q <= 1'b1;
                end
            end
        end
    end

    // Response merge
    always_comb begin
        case (sel)
            SEL_RAM0: begin
                ack_o    = ram0_ack_i;
                seqslv_o = ram0_seqslv_i;
                rdata_o  = ram0_rdata_i;
            end
            SEL_RAM1: begin
                ack_o    = ram1_ack_i;
                seqslv_o = ram1_seqslv_i;
                rdata_o  = ram1_rdata_i;
            end
            default: begin
                ack_o    = nm_ack_q;
                seqslv_o = nm_seqslv_q;
                rdata_o  = '0;
            end
        endcase
    end

endmodule

/* hdl/pkbus_ram.sv */
// Byte-organized PKBus RAM slave with a fixed number of wait states
// Serves byte, word and four-beat tword transfers, addresses wrap inside the region
`timescale 1ns/100ps
`include "pkbus_consts.svh"

module pkbus_ram import pkbus_pkg::*; #(
    parameter int unsigned WAIT_CYCLES = 0
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      req_i,
    input  bus_rw_t                   rw_i,
    input  bus_size_t                 size_i,
    input  logic [`BUS_ADDR_SIZE-1:0] addr_i,  // Offset inside the region
    input  logic [`BUS_DATA_SIZE-1:0] wdata_i,
    output logic                      ack_o,
    output logic                      seqslv_o,
    output logic [`BUS_DATA_SIZE-1:0] rdata_o
);

    localparam int unsigned AW = $clog2(`RAM_BYTES);
    localparam int unsigned WW = $clog2(WAIT_CYCLES + 1) + 1;

    logic [7:0]    mem [`RAM_BYTES];
    logic [WW-1:0] wait_q;
    logic [1:0]    beat_q;
    logic          done_q;    // All four tword beats served
    logic [AW-1:0] byte_addr;
    logic          idle;
    logic          fire;      // Response goes out at this edge

    assign byte_addr = addr_i[AW-1:0] + AW'({beat_q, 2'b00});
    assign idle      = req_i && !ack_o && !seqslv_o && !done_q;
    assign fire      = idle && (wait_q == WW'(WAIT_CYCLES));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_o    <= 1'b0;
            seqslv_o <= 1'b0;
            wait_q   <= '0;
            beat_q   <= 2'd0;
            done_q   <= 1'b0;
        end else begin
            seqslv_o <= 1'b0;
            if (!req_i) begin
                ack_o  <= 1'b0;
                wait_q <= '0;
                beat_q <= 2'd0;
                done_q <= 1'b0;
            end else if (fire) begin
                wait_q <= '0;
                if (size_i == SIZE_TWORD) begin
                    seqslv_o <= 1'b1;
                    beat_q   <= beat_q + 2'd1;
                    done_q   <= (beat_q == 2'd3);
                end else begin
                    ack_o <= 1'b1; // Held until req falls
                end
            end else if (idle) begin
                wait_q <= wait_q + WW'(1);
            end
        end
    end

    // Storage, little-endian
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `RAM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (fire && rw_i == BUS_WRITE) begin
            if (size_i == SIZE_BYTE) begin
                mem[byte_addr] <= wdata_i[7:0];
            end else begin
                for (int k = 0; k < 4; k++) begin
                    mem[byte_addr + AW'(k)] <= wdata_i[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire && rw_i == BUS_READ) begin
            if (size_i == SIZE_BYTE) begin
                rdata_o <= {{(`BUS_DATA_SIZE-8){1'b0}}, mem[byte_addr]};
            end else begin
                for (int k = 0; k < 4; k++) begin
                    rdata_o[8*k +: 8] <= mem[byte_addr + AW'(k)];
                end
            end
        end
    end

endmodule

/* hdl/pkbus_master.sv */
// PKBus master engine, runs one bus transfer per command on the four-phase command port
// Byte, word and tword transfers, read data is returned on cmd_rdata_o while cmd_ack_o is high
`timescale 1ns/100ps
`include "pkbus_consts.svh"

module pkbus_master import pkbus_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // Command port
    input  logic                          cmd_req_i,
    input  bus_rw_t                       cmd_rw_i,
    input  bus_size_t                     cmd_size_i,
    input  logic [`BUS_ADDR_SIZE-1:0]     cmd_addr_i,
    input  logic [4*`BUS_DATA_SIZE-1:0]   cmd_wdata_i,
    output logic                          cmd_ack_o,
    output logic [4*`BUS_DATA_SIZE-1:0]   cmd_rdata_o,

    // PKBus
    output logic                          bus_req_o,
    output bus_rw_t                       bus_rw_o,
    output bus_size_t                     bus_size_o,
    output logic [`BUS_ADDR_SIZE-1:0]     bus_addr_o,
    output logic [`BUS_DATA_SIZE-1:0]     bus_wdata_o,
    input  logic                          bus_ack_i,
    input  logic                          bus_seqslv_i,
    input  logic [`BUS_DATA_SIZE-1:0]     bus_rdata_i
);

    localparam int unsigned DW = `BUS_DATA_SIZE;
    localparam int unsigned CW = 4 * `BUS_DATA_SIZE;

    master_state_t   state_q;
    logic [1:0]      beat_q;   // Tword beats done so far
    logic [CW-1:0]   data_q;   // Read assembly or pending write beats
    logic            tword;
    logic            last_beat;

    assign tword     = (bus_size_o == SIZE_TWORD);
    assign last_beat = bus_seqslv_i && (beat_q == 2'd3);

    assign cmd_rdata_o = data_q;

    // Sequencing and handshake control
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= READY;
            beat_q    <= 2'd0;
            bus_req_o <= 1'b0;
            cmd_ack_o <= 1'b0;
        end else begin
            case (state_q)
                READY: begin
                    if (cmd_req_i) begin
                        bus_req_o <= 1'b1;
                        beat_q    <= 2'd0;
                        state_q   <= (cmd_rw_i == BUS_WRITE) ? WRITE : READ;
                    end
                end
                READ: begin
                    if (tword) begin
                        if (bus_seqslv_i) begin
                            beat_q <= beat_q + 2'd1;
                        end
                        if (last_beat) begin
                            bus_req_o <= 1'b0;
                            state_q   <= DONE;
                        end
                    end else if (bus_ack_i) begin
                        bus_req_o <= 1'b0;
                        state_q   <= DONE;
                    end
                end
                WRITE: begin
                    if (tword) begin
                        if (bus_seqslv_i) begin
                            beat_q <= beat_q + 2'd1;
                        end
                        if (last_beat) begin
                            bus_req_o <= 1'b0;
                            state_q   <= WRITE_FLUSH;
                        end
                    end else if (bus_ack_i) begin
                        bus_req_o <= 1'b0;
                        state_q   <= WRITE_FLUSH;
                    end
                end
                WRITE_FLUSH: begin
                    state_q <= DONE;
                end
                DONE: begin
                    // Bus stays idle for one cycle before the command completes
                    cmd_ack_o <= 1'b1;
                    state_q   <= CMD_ACK;
                end
                CMD_ACK: begin
                    if (!cmd_req_i) begin
                        cmd_ack_o <= 1'b0;
                        state_q   <= READY;
                    end
                end
                default: begin
                    state_q <= READY;
                end
            endcase
        end
    end

    // Bus fields and data buffer
    always_ff @(posedge clk_i) begin
        case (state_q)
            READY: begin
                if (cmd_req_i) begin
                    bus_rw_o   <= cmd_rw_i;
                    bus_addr_o <= cmd_addr_i;
                    bus_size_o <= (cmd_size_i == SIZE_STREAM) ? SIZE_WORD : cmd_size_i;
                    if (cmd_size_i == SIZE_BYTE) begin
                        bus_wdata_o <= {{(DW-8){1'b0}}, cmd_wdata_i[7:0]};
                    end else begin
                        bus_wdata_o <= cmd_wdata_i[DW-1:0];
                    end
                    if (cmd_rw_i == BUS_WRITE) begin
                        data_q <= {{DW{1'b0}}, cmd_wdata_i[CW-1:DW]}; // Beats 1 to 3 wait here
                    end else begin
                        data_q <= '0;
                    end
                end
            end
            READ: begin
                if (tword) begin
                    if (bus_seqslv_i) begin
                        data_q <= {bus_rdata_i, data_q[CW-1:DW]}; // Beat 0 ends in the low word
                    end
                end else if (bus_ack_i) begin
                    if (bus_size_o == SIZE_BYTE) begin
                        data_q <= {{(CW-8){1'b0}}, bus_rdata_i[7:0]};
                    end else begin
                        data_q <= {{(CW-DW){1'b0}}, bus_rdata_i};
                    end
                end
            end
            WRITE: begin
                if (tword && bus_seqslv_i) begin
                    bus_wdata_o <= data_q[DW-1:0]; // Next beat ready before the next pulse
                    data_q      <= {{DW{1'b0}}, data_q[CW-1:DW]};
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* hdl/mem_map_pkg.sv */
// Address map types of the PKBus segment
// Imported by the decoder and by anything that models the map

package mem_map_pkg;

    // Target of a bus address
    typedef enum logic [1:0] {
        SEL_RAM0 = 2'd0,
        SEL_RAM1 = 2'd1,
        SEL_NONE = 2'd2  // Unmapped, answered by the decoder
    } slave_sel_t;

endpackage

/* hdl/pkbus_pkg.sv */
// PKBus protocol types shared by the master, the slaves and the decoder
// Imported with a wildcard in the module header

package pkbus_pkg;

    // Transfer size carried on the bus
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_WORD   = 2'd1,
        SIZE_TWORD  = 2'd2, // Four beats, paced by seqslv
        SIZE_STREAM = 2'd3  // Reserved, handled as a word
    } bus_size_t;

    // Transfer direction
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_rw_t;

    // Master transfer sequence
    typedef enum logic [2:0] {
        READY       = 3'd0,
        READ        = 3'd1,
        WRITE       = 3'd2,
        WRITE_FLUSH = 3'd3, // Last write beat settles
        DONE        = 3'd4, // Idle cycle between bus actions
        CMD_ACK     = 3'd5
    } master_state_t;

endpackage

/* hdl/pkbus_consts.svh */
// Bus widths, RAM size and address map of the PKBus segment
// Included by every file that sizes a bus port or decodes an address
`ifndef PKBUS_CONSTS_SVH
`define PKBUS_CONSTS_SVH

// PKBus data and address widths in bits
`define BUS_DATA_SIZE 32
`define BUS_ADDR_SIZE 32

// Bytes held by each RAM slave
`define RAM_BYTES 1024

// Region bases, each region is RAM_BYTES long
`define RAM0_BASE 32'h0000_0000
`define RAM1_BASE 32'h0000_1000

`endif
